//--- run_sim.sh
#!/bin/sh
# build the memory subsystem testbench with Verilator and run it
# the exit status is the simulator's, nonzero on any failure
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal \
	-f vlog.f --top-module tb_mem_subsystem \
	--Mdir obj_dir -o tb_mem_subsystem \
	&& ./obj_dir/tb_mem_subsystem \
	|| { echo "simulation did not complete successfully"; exit 1; }

//--- source/axil_pkg.sv
`default_nettype none

package axil_pkg;

	// xRESP encodings of the bus
	typedef logic [1:0] axil_resp_t;

	localparam axil_resp_t RESP_OKAY   = 2'b00; // normal access done
	localparam axil_resp_t RESP_SLVERR = 2'b10; // slave signalled an error

	// AxPROT bits: [0] privileged, [1] non-secure, [2] instruction
	// all accesses here are unprivileged data accesses
	localparam logic [2:0] AXIL_PROT = 3'b000;

endpackage

`default_nettype wire

//--- source/dcache_dm.sv
`timescale 1ns/10ps
`default_nettype none

module dcache_dm
	import rv_mem_pkg::*;
	import axil_pkg::*;
#(
	parameter int CACHE_LINES = 16 // one word per line, power of two
)
(
	input  logic       i_clk,
	input  logic       i_reset,

	// request from the memory stage
	input  logic       i_req_valid,
	input  logic       i_req_write,
	input  addr_t      i_req_addr,
	input  word_t      i_req_wdata,
	input  strb_t      i_req_strb,
	output logic       o_req_ready,
	output logic       o_rsp_valid,
	output word_t      o_rsp_rdata,

	// axi4-lite master
	output logic       o_axi_awvalid,
	input  logic       i_axi_awready,
	output addr_t      o_axi_awaddr,
	output logic [2:0] o_axi_awprot,

	output logic       o_axi_wvalid,
	input  logic       i_axi_wready,
	output word_t      o_axi_wdata,
	output strb_t      o_axi_wstrb,

	input  logic       i_axi_bvalid,
	output logic       o_axi_bready,
	input  axil_resp_t i_axi_bresp,

	output logic       o_axi_arvalid,
	input  logic       i_axi_arready,
	output addr_t      o_axi_araddr,
	output logic [2:0] o_axi_arprot,

	input  logic       i_axi_rvalid,
	output logic       o_axi_rready,
	input  word_t      i_axi_rdata,
	input  axil_resp_t i_axi_rresp
);

	localparam int IDX_W = $clog2(CACHE_LINES);
	localparam int TAG_W = 30 - IDX_W; // word address bits above the index

	typedef enum logic [2:0] {
		IDLE,
		LOOKUP,     // tag compare, read hits answer here
		READ_ADDR,  // AR out
		READ_DATA,  // waiting for R
		WRITE,      // AW and W out
		WRITE_RESP  // waiting for B
	} state_t;

	state_t state, state_nxt;

	logic [CACHE_LINES-1:0] line_valid;
	logic [TAG_W-1:0]       line_tag [CACHE_LINES];
	word_t                  line_data [CACHE_LINES];

	// latched request
	logic  r_write;
	addr_t r_addr;
	word_t r_wdata;
	strb_t r_strb;

	logic             r_aw_pend; // AW not yet accepted
	logic             r_w_pend;  // W not yet accepted
	logic [IDX_W-1:0] idx;
	logic [TAG_W-1:0] tag;
	logic             hit;
	logic             aw_done;
	logic             w_done;

	assign idx     = r_addr[IDX_W+1:2];
	assign tag     = r_addr[31:IDX_W+2];
	assign hit     = line_valid[idx] && (line_tag[idx] == tag);
	assign aw_done = !r_aw_pend || i_axi_awready;
	assign w_done  = !r_w_pend || i_axi_wready;

	always_ff @(posedge i_clk or posedge i_reset) begin
		if (i_reset) begin
			state      <= IDLE;
			line_valid <= '0; // cold cache
			r_aw_pend  <= 1'b0;
			r_w_pend   <= 1'b0;
		end else begin
			state <= state_nxt;
			if (state == READ_DATA && i_axi_rvalid)
				line_valid[idx] <= 1'b1; // refill done
			if (state == LOOKUP && r_write) begin // raise both write channels together
				r_aw_pend <= 1'b1;
				r_w_pend  <= 1'b1;
			end else if (state == WRITE) begin
				if (i_axi_awready)
					r_aw_pend <= 1'b0;
				if (i_axi_wready)
					r_w_pend <= 1'b0;
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_req_valid && o_req_ready) begin
			r_write <= i_req_write;
			r_addr  <= i_req_addr;
			r_wdata <= i_req_wdata;
			r_strb  <= i_req_strb;
		end
		// write hit merges the strobed bytes, a write miss leaves the array alone
		if (state == LOOKUP && r_write && hit) begin
			for (int b = 0; b < 4; b++) begin
				if (r_strb[b])
					line_data[idx][8*b +: 8] <= r_wdata[8*b +: 8];
			end
		end
		if (state == READ_DATA && i_axi_rvalid) begin
			line_tag[idx]  <= tag;
			line_data[idx] <= i_axi_rdata;
		end
	end

	always_comb begin
		state_nxt   = state;
		o_rsp_valid = 1'b0;
		o_rsp_rdata = line_data[idx];
		case (state)
			IDLE: begin
				if (i_req_valid)
					state_nxt = LOOKUP;
			end
			LOOKUP: begin
				if (r_write)
					state_nxt = WRITE; // write-through, always goes to the bus
				else if (hit) begin
					o_rsp_valid = 1'b1;
					state_nxt   = IDLE;
				end else
					state_nxt = READ_ADDR;
			end
			READ_ADDR: begin
				if (i_axi_arready)
					state_nxt = READ_DATA;
			end
			READ_DATA: begin
				o_rsp_rdata = i_axi_rdata; // forward the fill word directly
				if (i_axi_rvalid) begin
					o_rsp_valid = 1'b1;
					state_nxt   = IDLE;
				end
			end
			WRITE: begin
				if (aw_done && w_done)
					state_nxt = WRITE_RESP;
			end
			WRITE_RESP: begin
				if (i_axi_bvalid) begin
					o_rsp_valid = 1'b1;
					state_nxt   = IDLE;
				end
			end
			default: state_nxt = IDLE;
		endcase
	end

	assign o_req_ready = (state == IDLE); // one request at a time

	// address and data are held in the request latch, so payload stays stable
	assign o_axi_awvalid = r_aw_pend;
	assign o_axi_awaddr  = {r_addr[31:2], 2'b00};
	assign o_axi_awprot  = AXIL_PROT;
	assign o_axi_wvalid  = r_w_pend;
	assign o_axi_wdata   = r_wdata;
	assign o_axi_wstrb   = r_strb;
	assign o_axi_bready  = (state == WRITE_RESP);
	assign o_axi_arvalid = (state == READ_ADDR);
	assign o_axi_araddr  = {r_addr[31:2], 2'b00};
	assign o_axi_arprot  = AXIL_PROT;
	assign o_axi_rready  = (state == READ_DATA);

endmodule

`default_nettype wire

//--- source/mem_stage.sv
`timescale 1ns/10ps
`default_nettype none

module mem_stage
	import rv_mem_pkg::*;
(
	input  logic     i_clk,
	input  logic     i_reset,

	// from the execute stage
	input  logic     i_valid_mem,  // load or store
	input  logic     i_mem_write,  // store when high
	input  funct3_t  i_funct3,
	input  reg_idx_t i_rd,
	input  addr_t    i_alu_result, // effective address or plain alu result
	input  word_t    i_rs2,        // store operand

	// to write-back
	output reg_idx_t o_rd,
	output word_t    o_rd_output,
	output logic     o_pipeline_ready,

	// cache side
	output logic     o_c_req_valid,
	output logic     o_c_req_write,
	output addr_t    o_c_req_addr,
	output word_t    o_c_req_wdata,
	output strb_t    o_c_req_strb,
	input  logic     i_c_req_ready,
	input  logic     i_c_rsp_valid,
	input  word_t    i_c_rsp_rdata,

	// mmio side
	output logic     o_m_req_valid,
	output logic     o_m_req_write,
	output addr_t    o_m_req_addr,
	output word_t    o_m_req_wdata,
	output strb_t    o_m_req_strb,
	input  logic     i_m_req_ready,
	input  logic     i_m_rsp_valid,
	input  word_t    i_m_rsp_rdata
);

	typedef enum logic {
		STANDBY, // idle or waiting to issue
		ACCESS   // request out, waiting for the answer
	} state_t;

	state_t state, state_nxt;

	// pipeline register
	logic     r_valid_mem;
	logic     r_mem_write;
	funct3_t  r_funct3;
	reg_idx_t r_rd;
	addr_t    r_alu_result;
	word_t    r_rs2;

	logic       sel_mmio;    // current access targets the register block
	logic [1:0] byte_off;    // byte offset inside the word
	strb_t      st_strb;
	word_t      st_wdata;
	addr_t      req_addr;
	logic       issue;       // one-cycle request pulse
	logic       tgt_ready;
	logic       tgt_rsp_valid;
	word_t      tgt_rsp_rdata;
	word_t      rsp_shifted; // addressed lanes moved down to bit 0
	word_t      ld_value;

	always_ff @(posedge i_clk or posedge i_reset) begin
		if (i_reset) begin
			state        <= STANDBY;
			r_valid_mem  <= 1'b0; // bubble, stage is ready out of reset
			r_mem_write  <= 1'b0;
			r_funct3     <= F3_WORD;
			r_rd         <= '0;
			r_alu_result <= '0;
			r_rs2        <= '0;
		end else begin
			state <= state_nxt;
			if (o_pipeline_ready) begin // advance only when the stage is done
				r_valid_mem  <= i_valid_mem;
				r_mem_write  <= i_mem_write;
				r_funct3     <= i_funct3;
				r_rd         <= i_rd;
				r_alu_result <= i_alu_result;
				r_rs2        <= i_rs2;
			end
		end
	end

	assign sel_mmio = |(r_alu_result & MMIO_BASE);
	assign byte_off = r_alu_result[1:0];
	assign req_addr = {r_alu_result[31:2], 2'b00}; // targets only see whole words

	// store lane placement, operand is replicated and the strobe picks the lanes
	always_comb begin
		st_strb  = '0;
		st_wdata = r_rs2;
		case (r_funct3)
			F3_BYTE: begin
				st_strb  = strb_t'(4'b0001 << byte_off);
				st_wdata = {4{r_rs2[7:0]}};
			end
			F3_HALF: begin
				st_strb  = byte_off[1] ? 4'b1100 : 4'b0011; // upper or lower half
				st_wdata = {2{r_rs2[15:0]}};
			end
			F3_WORD: st_strb = 4'b1111;
			default: st_strb = 4'b0000; // not a store width, write nothing
		endcase
	end

	// answer comes from whichever target got the request
	assign tgt_ready     = sel_mmio ? i_m_req_ready : i_c_req_ready;
	assign tgt_rsp_valid = sel_mmio ? i_m_rsp_valid : i_c_rsp_valid;
	assign tgt_rsp_rdata = sel_mmio ? i_m_rsp_rdata : i_c_rsp_rdata;

	// load extraction and extension
	assign rsp_shifted = tgt_rsp_rdata >> {byte_off, 3'b000};

	always_comb begin
		case (r_funct3)
			F3_BYTE:   ld_value = {{24{rsp_shifted[7]}}, rsp_shifted[7:0]};
			F3_BYTE_U: ld_value = {24'b0, rsp_shifted[7:0]};
			F3_HALF:   ld_value = {{16{rsp_shifted[15]}}, rsp_shifted[15:0]};
			F3_HALF_U: ld_value = {16'b0, rsp_shifted[15:0]};
			default:   ld_value = tgt_rsp_rdata; // lw
		endcase
	end

	always_comb begin
		state_nxt        = state;
		issue            = 1'b0;
		o_pipeline_ready = 1'b0;
		o_rd_output      = r_alu_result; // non-memory ops pass the alu result
		case (state)
			STANDBY: begin
				o_pipeline_ready = !r_valid_mem; // done at once without an access
				if (r_valid_mem && tgt_ready) begin
					issue     = 1'b1;
					state_nxt = ACCESS;
				end
			end
			ACCESS: begin
				if (!r_mem_write)
					o_rd_output = ld_value;
				if (tgt_rsp_valid) begin // release the pipeline with the answer
					o_pipeline_ready = 1'b1;
					state_nxt        = STANDBY;
				end
			end
			default: state_nxt = STANDBY;
		endcase
	end

	assign o_rd = r_rd;

	// request fan-out, valid only to the selected target
	assign o_c_req_valid = issue && !sel_mmio;
	assign o_c_req_write = r_mem_write;
	assign o_c_req_addr  = req_addr;
	assign o_c_req_wdata = st_wdata;
	assign o_c_req_strb  = st_strb;

	assign o_m_req_valid = issue && sel_mmio;
	assign o_m_req_write = r_mem_write;
	assign o_m_req_addr  = req_addr;
	assign o_m_req_wdata = st_wdata;
	assign o_m_req_strb  = st_strb;

endmodule

`default_nettype wire

//--- source/mem_subsystem_top.sv
`timescale 1ns/10ps
`default_nettype none

module mem_subsystem_top
	import rv_mem_pkg::*;
	import axil_pkg::*;
#(
	parameter int CACHE_LINES = 16
)
(
	input  logic       i_clk,
	input  logic       i_reset,

	// pipeline side
	input  logic       i_valid_mem,
	input  logic       i_mem_write,
	input  funct3_t    i_funct3,
	input  reg_idx_t   i_rd,
	input  addr_t      i_alu_result,
	input  word_t      i_rs2,
	output reg_idx_t   o_rd,
	output word_t      o_rd_output,
	output logic       o_pipeline_ready,

	// axi4-lite toward memory
	output logic       o_axi_awvalid,
	input  logic       i_axi_awready,
	output addr_t      o_axi_awaddr,
	output logic [2:0] o_axi_awprot,
	output logic       o_axi_wvalid,
	input  logic       i_axi_wready,
	output word_t      o_axi_wdata,
	output strb_t      o_axi_wstrb,
	input  logic       i_axi_bvalid,
	output logic       o_axi_bready,
	input  axil_resp_t i_axi_bresp,
	output logic       o_axi_arvalid,
	input  logic       i_axi_arready,
	output addr_t      o_axi_araddr,
	output logic [2:0] o_axi_arprot,
	input  logic       i_axi_rvalid,
	output logic       o_axi_rready,
	input  word_t      i_axi_rdata,
	input  axil_resp_t i_axi_rresp
);

	// stage <-> cache
	logic  c_req_valid, c_req_write, c_req_ready, c_rsp_valid;
	addr_t c_req_addr;
	word_t c_req_wdata, c_rsp_rdata;
	strb_t c_req_strb;

	// stage <-> register block
	logic  m_req_valid, m_req_write, m_req_ready, m_rsp_valid;
	addr_t m_req_addr;
	word_t m_req_wdata, m_rsp_rdata;
	strb_t m_req_strb;

	mem_stage u_mem_stage (
		.i_clk            (i_clk),
		.i_reset          (i_reset),
		.i_valid_mem      (i_valid_mem),
		.i_mem_write      (i_mem_write),
		.i_funct3         (i_funct3),
		.i_rd             (i_rd),
		.i_alu_result     (i_alu_result),
		.i_rs2            (i_rs2),
		.o_rd             (o_rd),
		.o_rd_output      (o_rd_output),
		.o_pipeline_ready (o_pipeline_ready),
		.o_c_req_valid    (c_req_valid),
		.o_c_req_write    (c_req_write),
		.o_c_req_addr     (c_req_addr),
		.o_c_req_wdata    (c_req_wdata),
		.o_c_req_strb     (c_req_strb),
		.i_c_req_ready    (c_req_ready),
		.i_c_rsp_valid    (c_rsp_valid),
		.i_c_rsp_rdata    (c_rsp_rdata),
		.o_m_req_valid    (m_req_valid),
		.o_m_req_write    (m_req_write),
		.o_m_req_addr     (m_req_addr),
		.o_m_req_wdata    (m_req_wdata),
		.o_m_req_strb     (m_req_strb),
		.i_m_req_ready    (m_req_ready),
		.i_m_rsp_valid    (m_rsp_valid),
		.i_m_rsp_rdata    (m_rsp_rdata)
	);

	dcache_dm #(
		.CACHE_LINES (CACHE_LINES)
	) u_dcache (
		.i_clk         (i_clk),
		.i_reset       (i_reset),
		.i_req_valid   (c_req_valid),
		.i_req_write   (c_req_write),
		.i_req_addr    (c_req_addr),
		.i_req_wdata   (c_req_wdata),
		.i_req_strb    (c_req_strb),
		.o_req_ready   (c_req_ready),
		.o_rsp_valid   (c_rsp_valid),
		.o_rsp_rdata   (c_rsp_rdata),
		.o_axi_awvalid (o_axi_awvalid),
		.i_axi_awready (i_axi_awready),
		.o_axi_awaddr  (o_axi_awaddr),
		.o_axi_awprot  (o_axi_awprot),
		.o_axi_wvalid  (o_axi_wvalid),
		.i_axi_wready  (i_axi_wready),
		.o_axi_wdata   (o_axi_wdata),
		.o_axi_wstrb   (o_axi_wstrb),
		.i_axi_bvalid  (i_axi_bvalid),
		.o_axi_bready  (o_axi_bready),
		.i_axi_bresp   (i_axi_bresp),
		.o_axi_arvalid (o_axi_arvalid),
		.i_axi_arready (i_axi_arready),
		.o_axi_araddr  (o_axi_araddr),
		.o_axi_arprot  (o_axi_arprot),
		.i_axi_rvalid  (i_axi_rvalid),
		.o_axi_rready  (o_axi_rready),
		.i_axi_rdata   (i_axi_rdata),
		.i_axi_rresp   (i_axi_rresp)
	);

	mmio_regs u_mmio (
		.i_clk       (i_clk),
		.i_reset     (i_reset),
		.i_req_valid (m_req_valid),
		.i_req_write (m_req_write),
		.i_req_addr  (m_req_addr),
		.i_req_wdata (m_req_wdata),
		.i_req_strb  (m_req_strb),
		.o_req_ready (m_req_ready),
		.o_rsp_valid (m_rsp_valid),
		.o_rsp_rdata (m_rsp_rdata)
	);

endmodule

`default_nettype wire

//--- source/mmio_regs.sv
`timescale 1ns/10ps
`default_nettype none

module mmio_regs
	import rv_mem_pkg::*;
(
	input  logic  i_clk,
	input  logic  i_reset,
	input  logic  i_req_valid,
	input  logic  i_req_write,
	input  addr_t i_req_addr,
	input  word_t i_req_wdata,
	input  strb_t i_req_strb,
	output logic  o_req_ready,
	output logic  o_rsp_valid,
	output word_t o_rsp_rdata
);

	logic        r_rsp_pend; // answer goes out this cycle
	word_t       r_scratch;
	word_t       r_cycles;   // free-running since reset
	word_t       r_rdata;
	logic [28:0] word_off;   // word offset inside the mmio region
	logic        req_fire;

	assign word_off = i_req_addr[30:2];
	assign req_fire = i_req_valid && o_req_ready;

	always_ff @(posedge i_clk or posedge i_reset) begin
		if (i_reset) begin
			r_rsp_pend <= 1'b0;
			r_scratch  <= '0;
			r_cycles   <= '0;
		end else begin
			r_cycles   <= r_cycles + 32'd1;
			r_rsp_pend <= req_fire;
			if (req_fire && i_req_write && word_off == 29'd0) begin
				for (int b = 0; b < 4; b++) begin
					if (i_req_strb[b])
						r_scratch[8*b +: 8] <= i_req_wdata[8*b +: 8];
				end
			end
		end
	end

	// read data sampled with the request, unmapped offsets read zero
	always_ff @(posedge i_clk) begin
		if (req_fire) begin
			case (word_off)
				29'd0:   r_rdata <= r_scratch;
				29'd1:   r_rdata <= r_cycles; // counter value at request time
				default: r_rdata <= '0;
			endcase
		end
	end

	assign o_req_ready = !r_rsp_pend; // busy while answering
	assign o_rsp_valid = r_rsp_pend;
	assign o_rsp_rdata = r_rdata;

endmodule

`default_nettype wire

//--- source/rv_mem_pkg.sv
`default_nettype none

package rv_mem_pkg;

	// basic datapath widths on the core side of the stage
	typedef logic [31:0] word_t;   // one data word
	typedef logic [31:0] addr_t;   // byte address out of the alu
	typedef logic [3:0]  strb_t;   // byte write enables, lane 0 is bits 7:0
	typedef logic [4:0]  reg_idx_t; // destination register index
	typedef logic [2:0]  funct3_t; // load/store width field of the instruction

	// funct3 encodings for loads and stores
	// bit 2 set selects zero extension on loads, stores only use 0..2
	localparam funct3_t F3_BYTE   = 3'd0; // lb / sb
	localparam funct3_t F3_HALF   = 3'd1; // lh / sh
	localparam funct3_t F3_WORD   = 3'd2; // lw / sw
	localparam funct3_t F3_BYTE_U = 3'd4; // lbu
	localparam funct3_t F3_HALF_U = 3'd5; // lhu

	// mmio region, any address with bit 31 set goes to the register block
	// everything below it is cacheable memory
	localparam addr_t MMIO_BASE = 32'h8000_0000;

endpackage

`default_nettype wire

//--- verification/axil_mem_model.sv
`timescale 1ns/10ps
`default_nettype none

module axil_mem_model
	import axil_pkg::*;
(
	input  logic        i_clk,
	input  logic        i_reset,
	input  logic        i_awvalid,
	output logic        o_awready,
	input  logic [31:0] i_awaddr,
	input  logic        i_wvalid,
	output logic        o_wready,
	input  logic [31:0] i_wdata,
	input  logic [3:0]  i_wstrb,
	output logic        o_bvalid,
	input  logic        i_bready,
	output axil_resp_t  o_bresp,
	input  logic        i_arvalid,
	output logic        o_arready,
	input  logic [31:0] i_araddr,
	output logic        o_rvalid,
	input  logic        i_rready,
	output logic [31:0] o_rdata,
	output axil_resp_t  o_rresp
);

	logic [31:0] mem [256]; // 1 KiB backing store, word indexed
	logic [7:0]  aw_idx;
	logic [7:0]  ar_idx;
	logic [31:0] w_data;
	logic [3:0]  w_strb;
	logic        aw_got;    // address of the pending write taken
	logic        w_got;     // data of the pending write taken
	logic        r_pend;    // read address taken, data not yet out
	logic [1:0]  aw_dly;
	logic [1:0]  w_dly;
	logic [1:0]  ar_dly;
	logic [1:0]  r_dly;

	always_ff @(posedge i_clk or posedge i_reset) begin
		if (i_reset) begin
			for (int i = 0; i < 256; i++)
				mem[i] <= (32'(i) * 32'h0101_0101) ^ 32'hA5A5_A5A5;
			o_awready <= 1'b0;
			o_wready  <= 1'b0;
			o_bvalid  <= 1'b0;
			o_arready <= 1'b0;
			o_rvalid  <= 1'b0;
			o_rdata   <= '0;
			aw_idx    <= '0;
			ar_idx    <= '0;
			w_data    <= '0;
			w_strb    <= '0;
			aw_got    <= 1'b0;
			w_got     <= 1'b0;
			r_pend    <= 1'b0;
			aw_dly    <= '0;
			w_dly     <= '0;
			ar_dly    <= '0;
			r_dly     <= '0;
		end else begin
			if (i_awvalid && o_awready) begin // AW taken, pick the next stall
				o_awready <= 1'b0;
				aw_got    <= 1'b1;
				aw_idx    <= i_awaddr[9:2];
				aw_dly    <= 2'($urandom % 4);
			end else if (i_awvalid && !aw_got) begin
				if (aw_dly == 2'd0)
					o_awready <= 1'b1;
				else
					aw_dly <= aw_dly - 2'd1;
			end
			if (i_wvalid && o_wready) begin
				o_wready <= 1'b0;
				w_got    <= 1'b1;
				w_data   <= i_wdata;
				w_strb   <= i_wstrb;
				w_dly    <= 2'($urandom % 4);
			end else if (i_wvalid && !w_got) begin
				if (w_dly == 2'd0)
					o_wready <= 1'b1;
				else
					w_dly <= w_dly - 2'd1;
			end
			// both halves in, commit under the strobe and answer
			if (aw_got && w_got && !o_bvalid) begin
				for (int b = 0; b < 4; b++) begin
					if (w_strb[b])
						mem[aw_idx][8*b +: 8] <= w_data[8*b +: 8];
				end
				o_bvalid <= 1'b1;
				aw_got   <= 1'b0;
				w_got    <= 1'b0;
			end
			if (o_bvalid && i_bready)
				o_bvalid <= 1'b0;
			if (i_arvalid && o_arready) begin
				o_arready <= 1'b0;
				r_pend    <= 1'b1;
				ar_idx    <= i_araddr[9:2];
				ar_dly    <= 2'($urandom % 4);
				r_dly     <= 2'($urandom % 4); // data comes back after its own stall
			end else if (i_arvalid && !r_pend) begin
				if (ar_dly == 2'd0)
					o_arready <= 1'b1;
				else
					ar_dly <= ar_dly - 2'd1;
			end
			if (r_pend && !o_rvalid) begin
				if (r_dly == 2'd0) begin
					o_rvalid <= 1'b1;
					o_rdata  <= mem[ar_idx];
					r_pend   <= 1'b0;
				end else
					r_dly <= r_dly - 2'd1;
			end
			if (o_rvalid && i_rready)
				o_rvalid <= 1'b0;
		end
	end

	assign o_bresp = RESP_OKAY; // memory never errors
	assign o_rresp = RESP_OKAY;

endmodule

`default_nettype wire

//--- verification/tb_mem_subsystem.sv
`timescale 1ns/10ps
`default_nettype none

module tb_mem_subsystem
	import rv_mem_pkg::*;
	import axil_pkg::*;
();

	localparam int N_INSTR = 44;          // instructions issued below including the final nop
	localparam int LIMIT   = 40 * N_INSTR; // cycle budget for the whole run

	logic       i_clk;
	logic       i_reset;
	logic       i_valid_mem;
	logic       i_mem_write;
	funct3_t    i_funct3;
	reg_idx_t   i_rd;
	addr_t      i_alu_result;
	word_t      i_rs2;
	reg_idx_t   o_rd;
	word_t      o_rd_output;
	logic       o_pipeline_ready;
	logic       axi_awvalid, axi_awready, axi_wvalid, axi_wready;
	logic       axi_bvalid, axi_bready, axi_arvalid, axi_arready;
	logic       axi_rvalid, axi_rready;
	addr_t      axi_awaddr, axi_araddr;
	logic [2:0] axi_awprot, axi_arprot;
	word_t      axi_wdata, axi_rdata;
	strb_t      axi_wstrb;
	axil_resp_t axi_bresp, axi_rresp;

	word_t    ref_mem [256]; // expected contents of the AXI memory
	word_t    ref_scratch;
	logic     in_alu;        // instruction on the inputs is not a memory op
	logic     in_fast;       // instruction on the inputs must answer one cycle after issue
	logic     hd_live;       // expectations of the instruction held in the stage
	logic     hd_chk;
	reg_idx_t hd_rd;
	word_t    hd_data;
	logic     hd_cache_st;
	logic     hd_cache_ld;
	addr_t    hd_addr;
	strb_t    hd_strb;
	word_t    hd_mask;
	word_t    hd_wdata;
	word_t    prev_result;   // o_rd_output seen when the last instruction was taken
	int       cyc;

	mem_subsystem_top #(.CACHE_LINES(16)) u_dut (
		.i_clk(i_clk), .i_reset(i_reset),
		.i_valid_mem(i_valid_mem), .i_mem_write(i_mem_write), .i_funct3(i_funct3),
		.i_rd(i_rd), .i_alu_result(i_alu_result), .i_rs2(i_rs2),
		.o_rd(o_rd), .o_rd_output(o_rd_output), .o_pipeline_ready(o_pipeline_ready),
		.o_axi_awvalid(axi_awvalid), .i_axi_awready(axi_awready),
		.o_axi_awaddr(axi_awaddr), .o_axi_awprot(axi_awprot),
		.o_axi_wvalid(axi_wvalid), .i_axi_wready(axi_wready),
		.o_axi_wdata(axi_wdata), .o_axi_wstrb(axi_wstrb),
		.i_axi_bvalid(axi_bvalid), .o_axi_bready(axi_bready), .i_axi_bresp(axi_bresp),
		.o_axi_arvalid(axi_arvalid), .i_axi_arready(axi_arready),
		.o_axi_araddr(axi_araddr), .o_axi_arprot(axi_arprot),
		.i_axi_rvalid(axi_rvalid), .o_axi_rready(axi_rready),
		.i_axi_rdata(axi_rdata), .i_axi_rresp(axi_rresp)
	);

	axil_mem_model u_mem (
		.i_clk(i_clk), .i_reset(i_reset),
		.i_awvalid(axi_awvalid), .o_awready(axi_awready), .i_awaddr(axi_awaddr),
		.i_wvalid(axi_wvalid), .o_wready(axi_wready),
		.i_wdata(axi_wdata), .i_wstrb(axi_wstrb),
		.o_bvalid(axi_bvalid), .i_bready(axi_bready), .o_bresp(axi_bresp),
		.i_arvalid(axi_arvalid), .o_arready(axi_arready), .i_araddr(axi_araddr),
		.o_rvalid(axi_rvalid), .i_rready(axi_rready),
		.o_rdata(axi_rdata), .o_rresp(axi_rresp)
	);

	always #2 i_clk = ~i_clk;

	always @(posedge i_clk) begin
		cyc <= cyc + 1;
		if (cyc >= LIMIT) begin
			$display("run stopped, no end of test after %0d cycles", cyc);
			$display("TB FAILED");
			$fatal(1);
		end
	end

	// write-back of the held instruction is checked on the edge that releases it
	assert property (@(posedge i_clk) disable iff (i_reset)
		(o_pipeline_ready && hd_live) |-> (o_rd == hd_rd))
	else begin
		$display("[ERROR] %0t o_rd: got %0d expected %0d", $time, $sampled(o_rd),
			$sampled(hd_rd));
		$display("TB FAILED");
		$fatal(1);
	end

	assert property (@(posedge i_clk) disable iff (i_reset)
		(o_pipeline_ready && hd_chk) |-> (o_rd_output == hd_data))
	else begin
		$display("[ERROR] %0t o_rd_output: got %h expected %h", $time,
			$sampled(o_rd_output), $sampled(hd_data));
		$display("TB FAILED");
		$fatal(1);
	end

	// alu op leaves the stage on the very next edge
	assert property (@(posedge i_clk) disable iff (i_reset)
		$past(o_pipeline_ready && in_alu) |-> o_pipeline_ready)
	else begin
		$display("non-memory instruction held the pipeline at %0t", $time);
		$display("TB FAILED");
		$fatal(1);
	end

	// hits and mmio issue one edge after capture and answer on the next
	assert property (@(posedge i_clk) disable iff (i_reset)
		$past(o_pipeline_ready && in_fast, 2) |-> (!$past(o_pipeline_ready) && o_pipeline_ready))
	else begin
		$display("access at %0t did not answer one cycle after its request", $time);
		$display("TB FAILED");
		$fatal(1);
	end

	assert property (@(posedge i_clk) disable iff (i_reset)
		(axi_awvalid || axi_wvalid) |-> hd_cache_st)
	else begin
		$display("AXI write at %0t without a cacheable store in the stage", $time);
		$display("TB FAILED");
		$fatal(1);
	end

	assert property (@(posedge i_clk) disable iff (i_reset)
		axi_arvalid |-> hd_cache_ld)
	else begin
		$display("AXI read at %0t without a cacheable load in the stage", $time);
		$display("TB FAILED");
		$fatal(1);
	end

	assert property (@(posedge i_clk) disable iff (i_reset)
		(axi_awvalid && axi_awready) |-> (axi_awaddr == hd_addr))
	else begin
		$display("[ERROR] %0t axi_awaddr: got %h expected %h", $time,
			$sampled(axi_awaddr), $sampled(hd_addr));
		$display("TB FAILED");
		$fatal(1);
	end

	assert property (@(posedge i_clk) disable iff (i_reset)
		axi_arvalid |-> (axi_araddr == hd_addr))
	else begin
		$display("[ERROR] %0t axi_araddr: got %h expected %h", $time,
			$sampled(axi_araddr), $sampled(hd_addr));
		$display("TB FAILED");
		$fatal(1);
	end

	// unprivileged data access, bit 1 is free
	assert property (@(posedge i_clk) disable iff (i_reset)
		axi_awvalid |-> ((axi_awprot & 3'b101) == 3'b000))
	else begin
		$display("[ERROR] %0t axi_awprot: got %b expected %b under mask 101", $time,
			$sampled(axi_awprot), 3'b000);
		$display("TB FAILED");
		$fatal(1);
	end

	assert property (@(posedge i_clk) disable iff (i_reset)
		axi_arvalid |-> ((axi_arprot & 3'b101) == 3'b000))
	else begin
		$display("[ERROR] %0t axi_arprot: got %b expected %b under mask 101", $time,
			$sampled(axi_arprot), 3'b000);
		$display("TB FAILED");
		$fatal(1);
	end

	assert property (@(posedge i_clk) disable iff (i_reset)
		(axi_wvalid && axi_wready) |-> (axi_wstrb == hd_strb))
	else begin
		$display("[ERROR] %0t axi_wstrb: got %b expected %b", $time,
			$sampled(axi_wstrb), $sampled(hd_strb));
		$display("TB FAILED");
		$fatal(1);
	end

	assert property (@(posedge i_clk) disable iff (i_reset)
		(axi_wvalid && axi_wready) |-> ((axi_wdata & hd_mask) == hd_wdata))
	else begin
		$display("[ERROR] %0t axi_wdata: got %h expected %h under mask %h", $time,
			$sampled(axi_wdata), $sampled(hd_wdata), $sampled(hd_mask));
		$display("TB FAILED");
		$fatal(1);
	end

	function automatic strb_t strobe_of(input logic [1:0] off, input funct3_t f3);
		case (f3[1:0])
			2'd0:    strobe_of = 4'b0001 << off;
			2'd1:    strobe_of = off[1] ? 4'b1100 : 4'b0011;
			default: strobe_of = 4'b1111;
		endcase
	endfunction

	// store operand placed in its lanes with the other lanes zero
	function automatic word_t placed_data(input word_t val, input logic [1:0] off,
			input funct3_t f3);
		case (f3[1:0])
			2'd0:    placed_data = {24'b0, val[7:0]} << (8 * off);
			2'd1:    placed_data = off[1] ? {val[15:0], 16'b0} : {16'b0, val[15:0]};
			default: placed_data = val;
		endcase
	endfunction

	function automatic word_t byte_mask(input strb_t s);
		for (int b = 0; b < 4; b++)
			byte_mask[8*b +: 8] = {8{s[b]}};
	endfunction

	function automatic word_t extend_load(input word_t w, input logic [1:0] off,
			input funct3_t f3);
		logic [7:0]  bt;
		logic [15:0] hw;
		bt = w[8*off +: 8];
		hw = off[1] ? w[31:16] : w[15:0];
		case (f3)
			F3_BYTE:   extend_load = {{24{bt[7]}}, bt};
			F3_BYTE_U: extend_load = {24'b0, bt};
			F3_HALF:   extend_load = {{16{hw[15]}}, hw};
			F3_HALF_U: extend_load = {16'b0, hw};
			default:   extend_load = w;
		endcase
	endfunction

	// present one instruction and hold it until the stage takes it
	task automatic present_instr(input logic vmem, input logic wr, input funct3_t f3,
			input reg_idx_t rd, input addr_t addr, input word_t rs2, input logic chk,
			input word_t exp, input logic fast);
		@(negedge i_clk);
		i_valid_mem  = vmem;
		i_mem_write  = wr;
		i_funct3     = f3;
		i_rd         = rd;
		i_alu_result = addr;
		i_rs2        = rs2;
		in_alu       = !vmem;
		in_fast      = fast;
		while (!o_pipeline_ready)
			@(negedge i_clk);
		prev_result = o_rd_output; // result of the instruction now leaving
		@(posedge i_clk);
		hd_live     = 1'b1;
		hd_chk      = chk;
		hd_rd       = rd;
		hd_data     = exp;
		hd_cache_st = vmem && wr && !addr[31];
		hd_cache_ld = vmem && !wr && !addr[31];
		hd_addr     = {addr[31:2], 2'b00};
		hd_strb     = strobe_of(addr[1:0], f3);
		hd_mask     = byte_mask(hd_strb);
		hd_wdata    = placed_data(rs2, addr[1:0], f3);
	endtask

	task automatic alu_op(input reg_idx_t rd, input word_t val);
		present_instr(1'b0, 1'b0, F3_WORD, rd, val, $urandom, 1'b1, val, 1'b0);
	endtask

	task automatic store_to(input funct3_t f3, input addr_t addr, input word_t val);
		word_t m;
		word_t d;
		m = byte_mask(strobe_of(addr[1:0], f3));
		d = placed_data(val, addr[1:0], f3);
		if (!addr[31])
			ref_mem[addr[9:2]] = (ref_mem[addr[9:2]] & ~m) | d;
		else if (addr[30:2] == '0)
			ref_scratch = (ref_scratch & ~m) | d; // counter and holes drop writes
		present_instr(1'b1, 1'b1, f3, 5'd0, addr, val, 1'b0, '0, addr[31]);
	endtask

	task automatic load_from(input funct3_t f3, input reg_idx_t rd, input addr_t addr,
			input logic fast);
		word_t w;
		if (!addr[31])
			w = ref_mem[addr[9:2]];
		else
			w = (addr[30:2] == '0) ? ref_scratch : '0;
		present_instr(1'b1, 1'b0, f3, rd, addr, '0, 1'b1, extend_load(w, addr[1:0], f3),
			fast);
	endtask

	initial begin
		word_t cnt_a;
		word_t cnt_b;
		void'($urandom(37));
		i_clk        = 1'b0;
		i_reset      = 1'b1;
		i_valid_mem  = 1'b0;
		i_mem_write  = 1'b0;
		i_funct3     = F3_WORD;
		i_rd         = '0;
		i_alu_result = '0;
		i_rs2        = '0;
		in_alu       = 1'b0;
		in_fast      = 1'b0;
		hd_live      = 1'b0;
		hd_chk       = 1'b0;
		hd_rd        = '0;
		hd_data      = '0;
		hd_cache_st  = 1'b0;
		hd_cache_ld  = 1'b0;
		hd_addr      = '0;
		hd_strb      = '0;
		hd_mask      = '0;
		hd_wdata     = '0;
		prev_result  = '0;
		cyc          = 0;
		ref_scratch  = '0;
		for (int i = 0; i < 256; i++)
			ref_mem[i] = (32'(i) * 32'h0101_0101) ^ 32'hA5A5_A5A5;
		repeat (10) @(posedge i_clk);
		@(negedge i_clk);
		i_reset = 1'b0;

		alu_op(5'd3, 32'h1234_5678);
		alu_op(5'd17, 32'hCAFE_0042);
		load_from(F3_WORD, 5'd4, 32'h40, 1'b0);  // cold miss
		load_from(F3_WORD, 5'd5, 32'h40, 1'b1);  // now a hit
		for (int off = 0; off < 4; off++)
			store_to(F3_BYTE, 32'h80 + off, $urandom); // write misses without allocation
		for (int off = 0; off < 4; off++) begin
			load_from(F3_BYTE, 5'd8, 32'h80 + off, 1'b0);
			load_from(F3_BYTE_U, 5'd9, 32'h80 + off, 1'b0);
		end
		for (int off = 0; off < 4; off += 2)
			store_to(F3_HALF, 32'h84 + off, $urandom);
		for (int off = 0; off < 4; off += 2) begin
			load_from(F3_HALF, 5'd10, 32'h84 + off, 1'b0);
			load_from(F3_HALF_U, 5'd11, 32'h84 + off, 1'b0);
		end
		load_from(F3_WORD, 5'd6, 32'h80, 1'b0);
		load_from(F3_WORD, 5'd7, 32'h84, 1'b0);
		store_to(F3_BYTE, 32'h81, $urandom);   // hits the filled line
		load_from(F3_WORD, 5'd6, 32'h80, 1'b1);
		store_to(F3_WORD, 32'h88, $urandom);
		load_from(F3_WORD, 5'd7, 32'h88, 1'b0);
		// 0x100 and 0x140 share line 0
		load_from(F3_WORD, 5'd20, 32'h100, 1'b0);
		load_from(F3_WORD, 5'd21, 32'h140, 1'b0);
		load_from(F3_WORD, 5'd22, 32'h100, 1'b0);
		load_from(F3_WORD, 5'd23, 32'h140, 1'b0);
		store_to(F3_WORD, 32'h100, $urandom);
		load_from(F3_WORD, 5'd24, 32'h140, 1'b0);
		load_from(F3_WORD, 5'd25, 32'h100, 1'b0);
		// register block
		store_to(F3_WORD, 32'h8000_0000, $urandom);
		store_to(F3_HALF, 32'h8000_0002, $urandom);
		load_from(F3_WORD, 5'd26, 32'h8000_0000, 1'b1);
		load_from(F3_BYTE, 5'd27, 32'h8000_0003, 1'b1);
		store_to(F3_WORD, 32'h8000_0004, $urandom); // counter is read-only
		present_instr(1'b1, 1'b0, F3_WORD, 5'd12, 32'h8000_0004, '0, 1'b0, '0, 1'b1);
		present_instr(1'b1, 1'b0, F3_WORD, 5'd13, 32'h8000_0004, '0, 1'b0, '0, 1'b1);
		cnt_a = prev_result;
		load_from(F3_WORD, 5'd14, 32'h8000_0008, 1'b1); // unmapped offset
		cnt_b = prev_result;
		assert (cnt_b > cnt_a) else begin
			$display("[ERROR] %0t cycle counter: first %h second %h", $time, cnt_a, cnt_b);
			$display("TB FAILED");
			$fatal(1);
		end
		alu_op(5'd0, 32'h0); // flushes the last result through the checks
		@(negedge i_clk);

		for (int i = 0; i < 256; i++) begin
			assert (u_mem.mem[i] == ref_mem[i]) else begin
				$display("[ERROR] %0t mem[%0d]: got %h expected %h", $time, i,
					u_mem.mem[i], ref_mem[i]);
				$display("TB FAILED");
				$fatal(1);
			end
		end
		$display("TB PASSED");
		$finish;
	end

endmodule

`default_nettype wire

//--- vlog.f
source/rv_mem_pkg.sv
source/axil_pkg.sv
source/mem_stage.sv
source/dcache_dm.sv
source/mmio_regs.sv
source/mem_subsystem_top.sv
verification/axil_mem_model.sv
verification/tb_mem_subsystem.sv
